/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = keypad_display_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* flist.f */
+incdir+logic
logic/ps2_pkg.sv
logic/display_pkg.sv
logic/ps2_receiver.sv
logic/key_state_tracker.sv
logic/digit_entry.sv
logic/seg_scanner.sv
logic/keypad_display_top.sv
verification/keypad_display_checker.sv
verification/keypad_display_tb.sv

/* logic/digit_entry.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keypad_params.svh"

module digit_entry (
    input  logic                    clk,
    input  logic                    rst,
    input  ps2_pkg::key_event_t     key_event,
    input  logic                    event_strobe,
    input  logic [511:0]            key_down,
    output display_pkg::hex_word_t  entry_word
);
    import ps2_pkg::*;
    import display_pkg::*;

    localparam logic [3:0] NOT_DIGIT = 4'hF;

    logic [3:0] digit_val;
    logic       shift_held;
    logic       take_digit;

    // extended codes have bit 8 set so never match
    always_comb begin
        case (key_event.code)
            `KP_CODE_DIGIT_0, `KP_CODE_PAD_0: digit_val = 4'd0;
            `KP_CODE_DIGIT_1, `KP_CODE_PAD_1: digit_val = 4'd1;
            `KP_CODE_DIGIT_2, `KP_CODE_PAD_2: digit_val = 4'd2;
            `KP_CODE_DIGIT_3, `KP_CODE_PAD_3: digit_val = 4'd3;
            `KP_CODE_DIGIT_4, `KP_CODE_PAD_4: digit_val = 4'd4;
            `KP_CODE_DIGIT_5, `KP_CODE_PAD_5: digit_val = 4'd5;
            `KP_CODE_DIGIT_6, `KP_CODE_PAD_6: digit_val = 4'd6;
            `KP_CODE_DIGIT_7, `KP_CODE_PAD_7: digit_val = 4'd7;
            `KP_CODE_DIGIT_8, `KP_CODE_PAD_8: digit_val = 4'd8;
            `KP_CODE_DIGIT_9, `KP_CODE_PAD_9: digit_val = 4'd9;
            default:                          digit_val = NOT_DIGIT;
        endcase
    end

    assign shift_held = key_down[`KP_CODE_LSHIFT] | key_down[`KP_CODE_RSHIFT];
    assign take_digit = event_strobe && key_event.make && !key_event.is_repeat &&
                        (digit_val != NOT_DIGIT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_word <= '1;   // four dashes
        end else if (take_digit) begin
            if (shift_held)
                entry_word <= {entry_word[2:0], digit_val};     // enter at the right
            else
                entry_word <= {digit_val, entry_word[3:1]};     // enter at the left
        end
    end

endmodule

`default_nettype wire

/* logic/display_pkg.sv */
`default_nettype none

package display_pkg;

    // index 0 is the low nibble, shown at pos0
    typedef logic [3:0][3:0] hex_word_t;

    typedef logic [3:0] digit_sel_t;    // active low
    typedef logic [6:0] seg_t;          // active low, bit 0 is segment a

    typedef enum logic [1:0] {
        POS0,
        POS1,
        POS2,
        POS3
    } scan_pos_e;

endpackage

`default_nettype wire

/* logic/key_state_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module key_state_tracker (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          rx_byte,
    input  logic                rx_strobe,
    output ps2_pkg::key_event_t key_event,
    output logic                event_strobe,
    output logic [511:0]        key_down
);
    import ps2_pkg::*;

    localparam logic [7:0] PREFIX_EXT = 8'hE0;
    localparam logic [7:0] PREFIX_BRK = 8'hF0;

    trk_state_e state;
    logic       ext_flag;
    logic       is_prefix;
    logic       make_now;
    scan_code_t code_full;

    assign is_prefix = (rx_byte == PREFIX_EXT) || (rx_byte == PREFIX_BRK);
    assign make_now  = (state != TRK_BRK);
    assign code_full = {ext_flag, rx_byte};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= TRK_IDLE;
            ext_flag     <= 1'b0;
            event_strobe <= 1'b0;
            key_down     <= '0;
        end else begin
            event_strobe <= 1'b0;
            if (rx_strobe) begin
                if (rx_byte == PREFIX_EXT) begin
                    ext_flag <= 1'b1;
                    state    <= TRK_EXT;
                end else if (rx_byte == PREFIX_BRK) begin
                    state <= TRK_BRK;   // ext_flag kept for E0 F0 xx
                end else begin
                    key_down[code_full] <= make_now;
                    event_strobe        <= 1'b1;
                    ext_flag            <= 1'b0;
                    state               <= TRK_IDLE;
                end
            end
        end
    end

    // event fields only valid with event_strobe
    always_ff @(posedge clk) begin
        if (rx_strobe && !is_prefix) begin
            key_event.code      <= code_full;
            key_event.make      <= make_now;
            key_event.is_repeat <= make_now && key_down[code_full];  // typematic
        end
    end

endmodule

`default_nettype wire

/* logic/keypad_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module keypad_display_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    output display_pkg::digit_sel_t digit,
    output display_pkg::seg_t       display
);
    import ps2_pkg::*;
    import display_pkg::*;

    logic [7:0]   rx_byte;
    logic         rx_strobe;
    key_event_t   key_event;
    logic         event_strobe;
    logic [511:0] key_down;
    hex_word_t    entry_word;

    ps2_receiver ps2_receiver_i (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    key_state_tracker key_state_tracker_i (
        .clk          (clk),
        .rst          (rst),
        .rx_byte      (rx_byte),
        .rx_strobe    (rx_strobe),
        .key_event    (key_event),
        .event_strobe (event_strobe),
        .key_down     (key_down)
    );

    digit_entry digit_entry_i (
        .clk          (clk),
        .rst          (rst),
        .key_event    (key_event),
        .event_strobe (event_strobe),
        .key_down     (key_down),
        .entry_word   (entry_word)
    );

    seg_scanner seg_scanner_i (
        .clk        (clk),
        .rst        (rst),
        .entry_word (entry_word),
        .digit      (digit),
        .display    (display)
    );

endmodule

`default_nettype wire

/* logic/keypad_params.svh */
`ifndef KEYPAD_PARAMS_SVH
`define KEYPAD_PARAMS_SVH

// display scan and PS/2 receiver timing, in clk cycles
`define KP_SCAN_TICKS   16
`define KP_PS2_TIMEOUT  100     // well above one PS/2 clock period

// shift keys
`define KP_CODE_LSHIFT  9'h012
`define KP_CODE_RSHIFT  9'h059

// top-row digits
`define KP_CODE_DIGIT_0 9'h045
`define KP_CODE_DIGIT_1 9'h016
`define KP_CODE_DIGIT_2 9'h01E
`define KP_CODE_DIGIT_3 9'h026
`define KP_CODE_DIGIT_4 9'h025
`define KP_CODE_DIGIT_5 9'h02E
`define KP_CODE_DIGIT_6 9'h036
`define KP_CODE_DIGIT_7 9'h03D
`define KP_CODE_DIGIT_8 9'h03E
`define KP_CODE_DIGIT_9 9'h046

// numeric keypad digits, non-extended
`define KP_CODE_PAD_0   9'h070
`define KP_CODE_PAD_1   9'h069
`define KP_CODE_PAD_2   9'h072
`define KP_CODE_PAD_3   9'h07A
`define KP_CODE_PAD_4   9'h06B
`define KP_CODE_PAD_5   9'h073
`define KP_CODE_PAD_6   9'h074
`define KP_CODE_PAD_7   9'h06C
`define KP_CODE_PAD_8   9'h075
`define KP_CODE_PAD_9   9'h07D

`endif

/* logic/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    // bit 8 set when the code came after an E0 prefix
    typedef logic [8:0] scan_code_t;

    // repeat is a reserved word, hence is_repeat
    typedef struct packed {
        scan_code_t code;
        logic       make;       // 1 press, 0 release
        logic       is_repeat;  // make on a key already held
    } key_event_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        TRK_IDLE,
        TRK_EXT,    // E0 seen
        TRK_BRK     // F0 seen
    } trk_state_e;

endpackage

`default_nettype wire

/* logic/ps2_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keypad_params.svh"

module ps2_receiver (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);
    import ps2_pkg::*;

    localparam int TIMEOUT = `KP_PS2_TIMEOUT;
    localparam int TW = $clog2(TIMEOUT);

    logic [1:0]    clk_sync;
    logic [1:0]    data_sync;
    logic          clk_prev;
    logic          fall;
    logic          data_bit;
    rx_state_e     state;
    logic [2:0]    bit_cnt;
    logic          parity_acc;
    logic          parity_ok;
    logic [7:0]    shift_reg;
    logic [TW-1:0] idle_cnt;
    logic          timeout;
    logic          frame_good;

    assign fall       = clk_prev & ~clk_sync[1];    // synchronized falling edge
    assign data_bit   = data_sync[1];
    assign timeout    = (state != RX_IDLE) && (idle_cnt == TW'(TIMEOUT - 1));
    assign frame_good = fall && (state == RX_STOP) && data_bit && parity_ok;

    // lines idle high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RX_IDLE;
            bit_cnt    <= 3'd0;
            parity_acc <= 1'b0;
            parity_ok  <= 1'b0;
            idle_cnt   <= '0;
            rx_strobe  <= 1'b0;
        end else begin
            rx_strobe <= frame_good;
            if (state == RX_IDLE || fall)
                idle_cnt <= '0;
            else
                idle_cnt <= idle_cnt + 1'b1;

            if (timeout) begin
                state <= RX_IDLE;   // drop the partial frame
            end else if (fall) begin
                case (state)
                    RX_IDLE: begin
                        if (!data_bit) begin    // start bit
                            state      <= RX_DATA;
                            bit_cnt    <= 3'd0;
                            parity_acc <= 1'b0;
                        end
                    end
                    RX_DATA: begin
                        parity_acc <= parity_acc ^ data_bit;
                        bit_cnt    <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= RX_PARITY;
                    end
                    RX_PARITY: begin
                        parity_ok <= parity_acc ^ data_bit;     // odd parity
                        state     <= RX_STOP;
                    end
                    default: state <= RX_IDLE;  // stop bit checked in frame_good
                endcase
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (fall && state == RX_DATA)
            shift_reg <= {data_bit, shift_reg[7:1]};
        if (frame_good)
            rx_byte <= shift_reg;
    end

endmodule

`default_nettype wire

/* logic/seg_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keypad_params.svh"

module seg_scanner (
    input  logic                   clk,
    input  logic                   rst,
    input  display_pkg::hex_word_t entry_word,
    output display_pkg::digit_sel_t digit,
    output display_pkg::seg_t      display
);
    import display_pkg::*;

    localparam int TICKS = `KP_SCAN_TICKS;
    localparam int CW = (TICKS > 1) ? $clog2(TICKS) : 1;

    logic [CW-1:0] tick_cnt;
    logic          tick;
    scan_pos_e     pos;
    scan_pos_e     next_pos;
    logic [3:0]    nibble;

    assign tick     = (tick_cnt == CW'(TICKS - 1));
    assign next_pos = scan_pos_e'(pos + 2'd1);

    // pos starts at pos3 so the first tick lights pos0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            pos      <= POS3;
            digit    <= '1;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick) begin
                pos   <= next_pos;
                digit <= ~(digit_sel_t'(1) << next_pos);
            end
        end
    end

    assign nibble = entry_word[pos];

    // gfedcba, low means lit
    always_comb begin
        case (nibble)
            4'd0:    display = 7'b1000000;
            4'd1:    display = 7'b1111001;
            4'd2:    display = 7'b0100100;
            4'd3:    display = 7'b0110000;
            4'd4:    display = 7'b0011001;
            4'd5:    display = 7'b0010010;
            4'd6:    display = 7'b0000010;
            4'd7:    display = 7'b1111000;
            4'd8:    display = 7'b0000000;
            4'd9:    display = 7'b0010000;
            4'd15:   display = 7'b0111111;  // dash
            default: display = 7'b1111111;  // blank
        endcase
    end

endmodule

`default_nettype wire

/* verification/keypad_display_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module keypad_display_checker (
    input logic                    clk,
    input logic                    rst,
    input display_pkg::digit_sel_t digit,
    input display_pkg::seg_t       display,
    input logic                    event_strobe
);
    int assert_fails = 0;   // read by the testbench at the end of the run

    // at most one digit lit at a time
    select_single: assert property (@(posedge clk) disable iff (rst)
        (digit == 4'b1111) || $onehot(~digit))
        else begin
            assert_fails++;
            $error("more than one digit select active at once");
        end

    strobe_pulse: assert property (@(posedge clk) disable iff (rst)
        event_strobe |=> !event_strobe)
        else begin
            assert_fails++;
            $error("event strobe held for two cycles");
        end

    display_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(display))
        else begin
            assert_fails++;
            $error("segment outputs unknown");
        end

endmodule

bind keypad_display_top keypad_display_checker assertions_i (
    .clk          (clk),
    .rst          (rst),
    .digit        (digit),
    .display      (display),
    .event_strobe (event_strobe)
);

`default_nettype wire

/* verification/keypad_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keypad_params.svh"

module keypad_display_tb;
    import ps2_pkg::*;
    import display_pkg::*;

    localparam int HALF = 10;                   // PS/2 clock half period, clk cycles
    localparam int GAP = 40;                    // idle time after each frame
    localparam int SEL_LIMIT = 8 * `KP_SCAN_TICKS;

    localparam scan_code_t TOP_ROW [10] = '{`KP_CODE_DIGIT_0, `KP_CODE_DIGIT_1,
        `KP_CODE_DIGIT_2, `KP_CODE_DIGIT_3, `KP_CODE_DIGIT_4, `KP_CODE_DIGIT_5,
        `KP_CODE_DIGIT_6, `KP_CODE_DIGIT_7, `KP_CODE_DIGIT_8, `KP_CODE_DIGIT_9};
    localparam scan_code_t KEYPAD [10] = '{`KP_CODE_PAD_0, `KP_CODE_PAD_1,
        `KP_CODE_PAD_2, `KP_CODE_PAD_3, `KP_CODE_PAD_4, `KP_CODE_PAD_5,
        `KP_CODE_PAD_6, `KP_CODE_PAD_7, `KP_CODE_PAD_8, `KP_CODE_PAD_9};
    // lit segments as gfedcba, active high, indexed by nibble
    localparam logic [6:0] LIT [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
        7'h7D, 7'h07, 7'h7F, 7'h6F, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h40};

    logic         clk;
    logic         rst;
    logic         ps2_clk;
    logic         ps2_data;
    digit_sel_t   digit;
    seg_t         display;
    logic [511:0] model_down;   // held keys as the model sees them
    hex_word_t    model_word;
    seg_t         shown [4];
    logic [31:0]  rng;
    int           checks;
    int           errors;

    keypad_display_top keypad_display_top_i (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .digit    (digit),
        .display  (display)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [3:0] digit_value(input scan_code_t code);
        int n;
        for (n = 0; n < 10; n++)
            if (code == TOP_ROW[n] || code == KEYPAD[n])
                return 4'(n);
        return 4'hF;    // not a digit
    endfunction

    // expected entry word after one key event
    function automatic hex_word_t ref_entry(input hex_word_t w, input scan_code_t code,
                                            input logic make, input logic rep,
                                            input logic shift);
        logic [3:0]  v;
        logic [15:0] flat;
        v = digit_value(code);
        flat = w;
        if (make && !rep && v != 4'hF)
            flat = shift ? ((flat << 4) | 16'(v)) : ((flat >> 4) | {v, 12'h000});
        return flat;
    endfunction

    function automatic seg_t seg_of(input logic [3:0] v);
        return ~LIT[v];
    endfunction

    function automatic logic [3:0] nibble_of(input seg_t s);
        int n;
        for (n = 0; n < 16; n++)
            if (seg_of(4'(n)) == s)
                return 4'(n);
        return 4'hA;
    endfunction

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, ~^data ^ bad_parity, data, 1'b0};   // stop, odd parity, data, start
        for (i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            step_cycles(HALF);
            ps2_clk = 1'b0;
            step_cycles(HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        step_cycles(GAP);
    endtask

    task automatic press(input scan_code_t code);
        logic rep;
        logic shift;
        if (code[8])
            send_byte(8'hE0, 1'b0);
        send_byte(code[7:0], 1'b0);
        rep = model_down[code];
        model_down[code] = 1'b1;
        shift = model_down[`KP_CODE_LSHIFT] | model_down[`KP_CODE_RSHIFT];
        model_word = ref_entry(model_word, code, 1'b1, rep, shift);
    endtask

    task automatic release_key(input scan_code_t code);
        if (code[8])
            send_byte(8'hE0, 1'b0);
        send_byte(8'hF0, 1'b0);
        send_byte(code[7:0], 1'b0);
        model_down[code] = 1'b0;
        model_word = ref_entry(model_word, code, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic release_shifts();
        if (model_down[`KP_CODE_LSHIFT])
            release_key(`KP_CODE_LSHIFT);
        if (model_down[`KP_CODE_RSHIFT])
            release_key(`KP_CODE_RSHIFT);
    endtask

    // one full scan, segments captured per position
    task automatic read_display();
        int   p;
        int   waited;
        int   limit;
        logic lost;
        p = 0;
        lost = 1'b0;
        while (p < 4 && !lost) begin
            waited = 0;
            limit = (p == 0) ? SEL_LIMIT : `KP_SCAN_TICKS + 1;  // next slot in scan order
            while (digit !== ~(4'b0001 << p) && waited < limit) begin
                @(negedge clk);
                waited++;
            end
            if (digit !== ~(4'b0001 << p)) begin
                lost = 1'b1;
            end else begin
                shown[p] = display;
                p++;
            end
        end
        if (lost) begin
            $display("timeout: digit select %0d not active within its scan slot", p);
            $display(">>> FAIL");
            $finish;
        end
    endtask

    task automatic check_sel(input digit_sel_t expected);
        checks++;
        if (digit !== expected) begin
            errors++;
            $display("FAIL @%0t: digit selects %b, expected %b", $time, digit, expected);
        end
    endtask

    task automatic check_seg(input int p, input seg_t expected);
        checks++;
        if (shown[p] !== expected) begin
            errors++;
            $display("FAIL @%0t: position %0d segments %b, expected %b",
                     $time, p, shown[p], expected);
        end
    endtask

    task automatic check_word(input hex_word_t expected);
        hex_word_t got;
        int        p;
        read_display();
        for (p = 0; p < 4; p++)
            got[p] = nibble_of(shown[p]);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL @%0t: display shows %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        if (errors == mark)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - mark);
    endtask

    initial begin
        int         mark;
        int         k;
        int         d;
        hex_word_t  saved;
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        model_down = '0;
        model_word = 16'hFFFF;
        rng = 32'h1543;
        checks = 0;
        errors = 0;
        step_cycles(8);
        rst = 1'b0;
        step_cycles(2);

        mark = errors;
        check_sel(4'b1111);     // nothing lit before the first scan tick
        read_display();
        for (k = 0; k < 4; k++)
            check_seg(k, seg_of(4'hF));
        check_word(16'hFFFF);
        report_test(1, "reset dashes", mark);

        mark = errors;
        for (k = 1; k <= 4; k++) begin
            press(TOP_ROW[k]);
            check_word(model_word);
            release_key(TOP_ROW[k]);
        end
        report_test(2, "top row no shift", mark);

        mark = errors;
        for (k = 0; k < 12; k++) begin
            rng = lcg_next(rng);
            d = int'(rng[19:16]) % 10;
            if (!rng[24])
                release_shifts();
            else if (!(model_down[`KP_CODE_LSHIFT] | model_down[`KP_CODE_RSHIFT]))
                press(rng[25] ? `KP_CODE_RSHIFT : `KP_CODE_LSHIFT);
            press(TOP_ROW[d]);
            check_word(model_word);
            release_key(TOP_ROW[d]);
        end
        release_shifts();
        report_test(3, "random digits and shift", mark);

        mark = errors;
        for (k = 7; k >= 5; k--) begin
            press(KEYPAD[k]);
            check_word(model_word);
            release_key(KEYPAD[k]);
        end
        saved = model_word;
        press(9'h170);  // E0 70, insert
        release_key(9'h170);
        check_word(saved);
        press(9'h01C);  // letter A
        release_key(9'h01C);
        check_word(saved);
        report_test(4, "keypad and non-digit keys", mark);

        mark = errors;
        press(TOP_ROW[5]);
        check_word(model_word);
        saved = model_word;
        press(TOP_ROW[5]);  // typematic repeats
        press(TOP_ROW[5]);
        check_word(saved);
        release_key(TOP_ROW[5]);
        press(TOP_ROW[5]);
        check_word(model_word);
        release_key(TOP_ROW[5]);
        report_test(5, "typematic repeat", mark);

        mark = errors;
        send_byte(TOP_ROW[2][7:0], 1'b1);
        check_word(model_word);
        press(TOP_ROW[8]);
        check_word(model_word);
        release_key(TOP_ROW[8]);
        report_test(6, "bad parity frame", mark);

        errors = errors + keypad_display_top_i.assertions_i.assert_fails;
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
